//--- hw/cache_cfg_pkg.sv
package cache_cfg_pkg;

	// Direct mapped, one word per line.
	localparam int INDEX_W = 4;
	localparam int TAG_W   = 6;
	localparam int LINES   = 1 << INDEX_W;

	// Cycles from a granted request to its ack.
	localparam int MEM_LAT = 4;

	localparam int CNT_W = 16;

endpackage

//--- hw/cache_subsys_top.sv
`timescale 1ns/1ps

module cache_subsys_top (
	input  logic                                clk_cpu,
	input  logic                                rst,
	input  logic                                run_i,
	input  logic                                load_we_i,
	input  logic [mem_map_pkg::WORD_ADDR_W-1:0] load_addr_i,
	input  logic [mem_map_pkg::DATA_W-1:0]      load_data_i,
	input  logic                                req_i,
	input  logic                                we_i,
	input  mem_map_pkg::mem_addr_u              addr_i,
	input  logic [mem_map_pkg::DATA_W-1:0]      wdata_i,
	input  logic [mem_map_pkg::STRB_W-1:0]      wstrb_i,
	output logic                                resp_o,
	output logic [mem_map_pkg::DATA_W-1:0]      rdata_o,
	output logic [cache_cfg_pkg::CNT_W-1:0]     ihit_cnt_o,
	output logic [cache_cfg_pkg::CNT_W-1:0]     imiss_cnt_o,
	output logic [cache_cfg_pkg::CNT_W-1:0]     dhit_cnt_o,
	output logic [cache_cfg_pkg::CNT_W-1:0]     dmiss_cnt_o
);
	import mem_map_pkg::*;

	// Router to caches.
	logic              ireq;
	mem_addr_u         ird_addr;
	logic              dreq;
	logic              dwe;
	mem_addr_u         dd_addr;
	logic [DATA_W-1:0] dwdata;
	logic [STRB_W-1:0] dwstrb;
	logic              iresp;
	logic [DATA_W-1:0] irdata;
	logic              dresp;
	logic [DATA_W-1:0] drdata;

	// Caches to memory.
	logic                   imem_req;
	logic [WORD_ADDR_W-1:0] imem_addr;
	logic                   imem_ack;
	logic [DATA_W-1:0]      imem_rdata;
	logic                   dmem_req;
	logic                   dmem_we;
	logic [WORD_ADDR_W-1:0] dmem_addr;
	logic [DATA_W-1:0]      dmem_wdata;
	logic [STRB_W-1:0]      dmem_wstrb;
	logic                   dmem_ack;
	logic [DATA_W-1:0]      dmem_rdata;

	cpu_port_router u_router (
		.clk_cpu (clk_cpu), .rst (rst), .run_i (run_i),
		.req_i (req_i), .we_i (we_i), .addr_i (addr_i),
		.wdata_i (wdata_i), .wstrb_i (wstrb_i),
		.iresp_i (iresp), .irdata_i (irdata), .dresp_i (dresp), .drdata_i (drdata),
		.ireq_o (ireq), .iaddr_o (ird_addr),
		.dreq_o (dreq), .dwe_o (dwe), .daddr_o (dd_addr),
		.dwdata_o (dwdata), .dwstrb_o (dwstrb),
		.resp_o (resp_o), .rdata_o (rdata_o)
	);

	inst_cache u_icache (
		.clk_cpu (clk_cpu), .rst (rst),
		.req_i (ireq), .addr_i (ird_addr),
		.mem_ack_i (imem_ack), .mem_rdata_i (imem_rdata),
		.resp_o (iresp), .rdata_o (irdata),
		.mem_req_o (imem_req), .mem_addr_o (imem_addr),
		.hit_cnt_o (ihit_cnt_o), .miss_cnt_o (imiss_cnt_o)
	);

	data_cache u_dcache (
		.clk_cpu (clk_cpu), .rst (rst),
		.req_i (dreq), .we_i (dwe), .addr_i (dd_addr),
		.wdata_i (dwdata), .wstrb_i (dwstrb),
		.mem_ack_i (dmem_ack), .mem_rdata_i (dmem_rdata),
		.resp_o (dresp), .rdata_o (drdata),
		.mem_req_o (dmem_req), .mem_we_o (dmem_we), .mem_addr_o (dmem_addr),
		.mem_wdata_o (dmem_wdata), .mem_wstrb_o (dmem_wstrb),
		.hit_cnt_o (dhit_cnt_o), .miss_cnt_o (dmiss_cnt_o)
	);

	main_memory u_mem (
		.clk_cpu (clk_cpu), .rst (rst),
		.load_we_i (load_we_i), .load_addr_i (load_addr_i), .load_data_i (load_data_i),
		.dreq_i (dmem_req), .dwe_i (dmem_we), .daddr_i (dmem_addr),
		.dwdata_i (dmem_wdata), .dwstrb_i (dmem_wstrb),
		.ireq_i (imem_req), .iaddr_i (imem_addr),
		.dack_o (dmem_ack), .drdata_o (dmem_rdata),
		.iack_o (imem_ack), .irdata_o (imem_rdata)
	);

endmodule

//--- hw/cpu_port_router.sv
`timescale 1ns/1ps

module cpu_port_router (
	input  logic                              clk_cpu,
	input  logic                              rst,
	input  logic                              run_i,
	input  logic                              req_i,
	input  logic                              we_i,
	input  mem_map_pkg::mem_addr_u            addr_i,
	input  logic [mem_map_pkg::DATA_W-1:0]    wdata_i,
	input  logic [mem_map_pkg::STRB_W-1:0]    wstrb_i,
	input  logic                              iresp_i,
	input  logic [mem_map_pkg::DATA_W-1:0]    irdata_i,
	input  logic                              dresp_i,
	input  logic [mem_map_pkg::DATA_W-1:0]    drdata_i,
	output logic                              ireq_o,
	output mem_map_pkg::mem_addr_u            iaddr_o,
	output logic                              dreq_o,
	output logic                              dwe_o,
	output mem_map_pkg::mem_addr_u            daddr_o,
	output logic [mem_map_pkg::DATA_W-1:0]    dwdata_o,
	output logic [mem_map_pkg::STRB_W-1:0]    dwstrb_o,
	output logic                              resp_o,
	output logic [mem_map_pkg::DATA_W-1:0]    rdata_o
);
	import mem_map_pkg::*;

	logic      accept;
	logic      to_inst;
	logic      pending;
	mem_addr_u addr_q;

	assign accept  = req_i && run_i;
	assign to_inst = !we_i && (addr_i.raw <= INST_LIMIT); // Only reads go to the I side.

	always_ff @(posedge clk_cpu) begin
		if (rst) begin
			ireq_o  <= 1'b0;
			dreq_o  <= 1'b0;
			pending <= 1'b0;
		end else begin
			ireq_o <= accept && to_inst;
			dreq_o <= accept && !to_inst;
			if (accept)
				pending <= 1'b1;
			else if (resp_o)
				pending <= 1'b0;
		end
	end

	// Request payload.
	always_ff @(posedge clk_cpu) begin
		if (accept) begin
			addr_q   <= addr_i;
			dwe_o    <= we_i;
			dwdata_o <= wdata_i;
			dwstrb_o <= wstrb_i;
		end
	end

	assign iaddr_o = addr_q;
	assign daddr_o = addr_q;

	// At most one cache answers.
	assign resp_o  = iresp_i || dresp_i;
	assign rdata_o = iresp_i ? irdata_i : drdata_i;

	// CPU may issue again in the response cycle.
	a_one_outstanding: assert property (@(posedge clk_cpu) disable iff (rst)
		(pending && !resp_o) |-> !(req_i && run_i));

	a_resp_exclusive: assert property (@(posedge clk_cpu) disable iff (rst)
		!(iresp_i && dresp_i));

endmodule

//--- hw/data_cache.sv
`timescale 1ns/1ps

module data_cache (
	input  logic                                clk_cpu,
	input  logic                                rst,
	input  logic                                req_i,
	input  logic                                we_i,
	input  mem_map_pkg::mem_addr_u              addr_i,
	input  logic [mem_map_pkg::DATA_W-1:0]      wdata_i,
	input  logic [mem_map_pkg::STRB_W-1:0]      wstrb_i,
	input  logic                                mem_ack_i,
	input  logic [mem_map_pkg::DATA_W-1:0]      mem_rdata_i,
	output logic                                resp_o,
	output logic [mem_map_pkg::DATA_W-1:0]      rdata_o,
	output logic                                mem_req_o,
	output logic                                mem_we_o,
	output logic [mem_map_pkg::WORD_ADDR_W-1:0] mem_addr_o,
	output logic [mem_map_pkg::DATA_W-1:0]      mem_wdata_o,
	output logic [mem_map_pkg::STRB_W-1:0]      mem_wstrb_o,
	output logic [cache_cfg_pkg::CNT_W-1:0]     hit_cnt_o,
	output logic [cache_cfg_pkg::CNT_W-1:0]     miss_cnt_o
);
	import mem_map_pkg::*;
	import cache_cfg_pkg::*;

	logic [LINES-1:0]  valid;
	logic [TAG_W-1:0]  tag_mem [LINES];
	logic [DATA_W-1:0] data_mem [LINES];

	logic               busy;
	logic [INDEX_W-1:0] idx;
	logic [INDEX_W-1:0] fill_idx;
	logic               hit;
	logic               fill;

	assign idx      = addr_i.f.index;
	assign hit      = valid[idx] && (tag_mem[idx] == addr_i.f.tag);
	assign fill_idx = mem_addr_o[INDEX_W-1:0];
	assign fill     = busy && mem_ack_i && !mem_we_o; // Read refill only.

	always_ff @(posedge clk_cpu) begin
		if (rst) begin
			valid      <= '0;
			busy       <= 1'b0;
			resp_o     <= 1'b0;
			mem_req_o  <= 1'b0;
			hit_cnt_o  <= '0;
			miss_cnt_o <= '0;
		end else begin
			resp_o    <= 1'b0;
			mem_req_o <= 1'b0;
			if (req_i) begin
				if (hit)
					hit_cnt_o <= hit_cnt_o + 1'b1;
				else
					miss_cnt_o <= miss_cnt_o + 1'b1;
				// Writes always go through to memory.
				if (hit && !we_i) begin
					resp_o <= 1'b1;
				end else begin
					mem_req_o <= 1'b1;
					busy      <= 1'b1;
				end
			end else if (busy && mem_ack_i) begin
				busy   <= 1'b0;
				resp_o <= 1'b1;
				if (fill)
					valid[fill_idx] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (req_i) begin
			rdata_o     <= data_mem[idx];
			mem_we_o    <= we_i;
			mem_addr_o  <= {addr_i.f.tag, addr_i.f.index};
			mem_wdata_o <= wdata_i;
			mem_wstrb_o <= wstrb_i;
			// Merge strobed bytes on a write hit.
			if (we_i && hit) begin
				for (int b = 0; b < STRB_W; b++) begin
					if (wstrb_i[b])
						data_mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
				end
			end
		end else if (fill) begin
			rdata_o            <= mem_rdata_i;
			data_mem[fill_idx] <= mem_rdata_i;
			tag_mem[fill_idx]  <= mem_addr_o[INDEX_W +: TAG_W];
		end
	end

endmodule

//--- hw/inst_cache.sv
`timescale 1ns/1ps

module inst_cache (
	input  logic                                clk_cpu,
	input  logic                                rst,
	input  logic                                req_i,
	input  mem_map_pkg::mem_addr_u              addr_i,
	input  logic                                mem_ack_i,
	input  logic [mem_map_pkg::DATA_W-1:0]      mem_rdata_i,
	output logic                                resp_o,
	output logic [mem_map_pkg::DATA_W-1:0]      rdata_o,
	output logic                                mem_req_o,
	output logic [mem_map_pkg::WORD_ADDR_W-1:0] mem_addr_o,
	output logic [cache_cfg_pkg::CNT_W-1:0]     hit_cnt_o,
	output logic [cache_cfg_pkg::CNT_W-1:0]     miss_cnt_o
);
	import mem_map_pkg::*;
	import cache_cfg_pkg::*;

	logic [LINES-1:0]  valid;
	logic [TAG_W-1:0]  tag_mem [LINES];
	logic [DATA_W-1:0] data_mem [LINES];

	logic               busy;
	logic [INDEX_W-1:0] idx;
	logic [INDEX_W-1:0] fill_idx;
	logic               hit;

	assign idx      = addr_i.f.index;
	assign hit      = valid[idx] && (tag_mem[idx] == addr_i.f.tag);
	assign fill_idx = mem_addr_o[INDEX_W-1:0];

	always_ff @(posedge clk_cpu) begin
		if (rst) begin
			valid      <= '0;
			busy       <= 1'b0;
			resp_o     <= 1'b0;
			mem_req_o  <= 1'b0;
			hit_cnt_o  <= '0;
			miss_cnt_o <= '0;
		end else begin
			resp_o    <= 1'b0;
			mem_req_o <= 1'b0;
			if (req_i) begin
				if (hit) begin
					resp_o    <= 1'b1; // Answer next cycle.
					hit_cnt_o <= hit_cnt_o + 1'b1;
				end else begin
					mem_req_o  <= 1'b1;
					busy       <= 1'b1;
					miss_cnt_o <= miss_cnt_o + 1'b1;
				end
			end else if (busy && mem_ack_i) begin
				busy            <= 1'b0;
				resp_o          <= 1'b1;
				valid[fill_idx] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (req_i) begin
			rdata_o    <= data_mem[idx];
			mem_addr_o <= {addr_i.f.tag, addr_i.f.index}; // Word address.
		end else if (busy && mem_ack_i) begin
			rdata_o            <= mem_rdata_i;
			data_mem[fill_idx] <= mem_rdata_i;
			tag_mem[fill_idx]  <= mem_addr_o[INDEX_W +: TAG_W];
		end
	end

	a_no_req_in_refill: assert property (@(posedge clk_cpu) disable iff (rst)
		busy |-> !req_i);

endmodule

//--- hw/main_memory.sv
`timescale 1ns/1ps

module main_memory (
	input  logic                                clk_cpu,
	input  logic                                rst,
	input  logic                                load_we_i,
	input  logic [mem_map_pkg::WORD_ADDR_W-1:0] load_addr_i,
	input  logic [mem_map_pkg::DATA_W-1:0]      load_data_i,
	input  logic                                dreq_i,
	input  logic                                dwe_i,
	input  logic [mem_map_pkg::WORD_ADDR_W-1:0] daddr_i,
	input  logic [mem_map_pkg::DATA_W-1:0]      dwdata_i,
	input  logic [mem_map_pkg::STRB_W-1:0]      dwstrb_i,
	input  logic                                ireq_i,
	input  logic [mem_map_pkg::WORD_ADDR_W-1:0] iaddr_i,
	output logic                                dack_o,
	output logic [mem_map_pkg::DATA_W-1:0]      drdata_o,
	output logic                                iack_o,
	output logic [mem_map_pkg::DATA_W-1:0]      irdata_o
);
	import mem_map_pkg::*;
	import cache_cfg_pkg::*;

	logic [DATA_W-1:0] mem [MEM_WORDS];

	logic                         busy;
	logic                         sel_d; // Latched request came from the D side.
	logic                         we_q;
	logic [WORD_ADDR_W-1:0]       addr_q;
	logic [DATA_W-1:0]            wdata_q;
	logic [STRB_W-1:0]            wstrb_q;
	logic [$clog2(MEM_LAT+1)-1:0] lat_cnt;
	logic [DATA_W-1:0]            rdata_q;
	logic                         fire;

	// Loader owns the array while it writes.
	assign fire = busy && !load_we_i && (lat_cnt == 1);

	always_ff @(posedge clk_cpu) begin
		if (rst) begin
			busy    <= 1'b0;
			lat_cnt <= '0;
			dack_o  <= 1'b0;
			iack_o  <= 1'b0;
		end else begin
			dack_o <= fire && sel_d;
			iack_o <= fire && !sel_d;
			if (!busy && (dreq_i || ireq_i)) begin
				busy    <= 1'b1;
				lat_cnt <= ($bits(lat_cnt))'(MEM_LAT - 1);
			end else if (fire) begin
				busy <= 1'b0;
			end else if (busy && !load_we_i) begin
				lat_cnt <= lat_cnt - 1'b1;
			end
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (!busy && (dreq_i || ireq_i)) begin
			sel_d   <= dreq_i; // Data before instruction.
			we_q    <= dreq_i && dwe_i;
			addr_q  <= dreq_i ? daddr_i : iaddr_i;
			wdata_q <= dwdata_i;
			wstrb_q <= dwstrb_i;
		end
		if (load_we_i) begin
			mem[load_addr_i] <= load_data_i;
		end else if (fire) begin
			if (we_q) begin
				for (int b = 0; b < STRB_W; b++) begin
					if (wstrb_q[b])
						mem[addr_q][8*b +: 8] <= wdata_q[8*b +: 8];
				end
			end else begin
				rdata_q <= mem[addr_q];
			end
		end
	end

	assign drdata_o = rdata_q;
	assign irdata_o = rdata_q;

	a_single_cache_req: assert property (@(posedge clk_cpu) disable iff (rst)
		!(ireq_i && dreq_i));

endmodule

//--- hw/mem_map_pkg.sv
package mem_map_pkg;

	localparam int ADDR_W      = 32;
	localparam int DATA_W      = 32;
	localparam int STRB_W      = DATA_W / 8;
	localparam int MEM_WORDS   = 1024;
	localparam int WORD_ADDR_W = $clog2(MEM_WORDS);
	localparam int OFFSET_W    = $clog2(STRB_W);

	// First 256 words hold instructions.
	localparam logic [ADDR_W-1:0] INST_LIMIT = ADDR_W'(256 * STRB_W - 1);

	localparam int UNUSED_W = ADDR_W - cache_cfg_pkg::TAG_W
		- cache_cfg_pkg::INDEX_W - OFFSET_W;

	// Byte address, seen raw by the router and as fields by the caches.
	typedef union packed {
		logic [ADDR_W-1:0] raw;
		struct packed {
			logic [UNUSED_W-1:0]             unused;
			logic [cache_cfg_pkg::TAG_W-1:0]   tag;
			logic [cache_cfg_pkg::INDEX_W-1:0] index;
			logic [OFFSET_W-1:0]             offset;
		} f;
	} mem_addr_u;

endpackage

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_cache_subsys -Mdir obj_dir -f verilog.f

out=$(./obj_dir/Vtb_cache_subsys) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q -x -F '>>> PASS'

//--- test/tb_stim_table.svh
`ifndef TB_STIM_TABLE_SVH
`define TB_STIM_TABLE_SVH

typedef struct {
	bit          we;
	logic [31:0] addr;
	logic [31:0] wdata;
	logic [3:0]  strb;
	bit          to_inst; // Filled by the model pass.
	bit          hit;
	logic [31:0] rdata;
} stim_entry_t;

localparam int N_ENTRIES = 26;

stim_entry_t stim_tab [N_ENTRIES];
int          n_built;

task automatic add_entry(input bit we, input logic [31:0] addr,
	input logic [31:0] wdata, input logic [3:0] strb);
	stim_tab[n_built].we    = we;
	stim_tab[n_built].addr  = addr;
	stim_tab[n_built].wdata = wdata;
	stim_tab[n_built].strb  = strb;
	n_built++;
endtask

task automatic build_table();
	logic [31:0] r;
	n_built = 0;
	// Fetch and refetch.
	add_entry(1'b0, 32'h0000_0040, '0, '0);
	add_entry(1'b0, 32'h0000_0040, '0, '0);
	r = lcg_next();
	add_entry(1'b0, {22'd0, r[9:2], 2'b00}, '0, '0);
	add_entry(1'b0, {22'd0, r[9:2], 2'b00}, '0, '0);
	// Write around, then read back.
	add_entry(1'b1, 32'h0000_0800, lcg_next(), 4'hf);
	add_entry(1'b0, 32'h0000_0800, '0, '0);
	// Byte merge on a cached word, evict, reread.
	add_entry(1'b1, 32'h0000_0800, lcg_next(), 4'b0101);
	add_entry(1'b0, 32'h0000_0800, '0, '0);
	add_entry(1'b0, 32'h0000_0c00, '0, '0);
	add_entry(1'b0, 32'h0000_0800, '0, '0);
	// Same index, different tags.
	add_entry(1'b0, 32'h0000_0484, '0, '0);
	add_entry(1'b0, 32'h0000_0884, '0, '0);
	add_entry(1'b0, 32'h0000_0484, '0, '0);
	add_entry(1'b0, 32'h0000_0884, '0, '0);
	for (int i = 0; i < 12; i++) begin
		r = lcg_next();
		if (r[31])
			add_entry(1'b0, {22'd0, r[9:2], 2'b00}, '0, '0);
		else
			add_entry(r[30], 32'h400 + ((r >> 2) % 768) * 4, lcg_next(), r[7:4]);
	end
endtask

`endif

//--- test/tb_cache_subsys.sv
`timescale 1ns/1ps

module tb_cache_subsys;
	import mem_map_pkg::*;
	import cache_cfg_pkg::*;

	logic                   clk_cpu;
	logic                   rst;
	logic                   run_i;
	logic                   load_we_i;
	logic [WORD_ADDR_W-1:0] load_addr_i;
	logic [DATA_W-1:0]      load_data_i;
	logic                   req_i;
	logic                   we_i;
	logic [ADDR_W-1:0]      addr_i;
	logic [DATA_W-1:0]      wdata_i;
	logic [STRB_W-1:0]      wstrb_i;
	logic                   resp_o;
	logic [DATA_W-1:0]      rdata_o;
	logic [CNT_W-1:0]       ihit_cnt_o;
	logic [CNT_W-1:0]       imiss_cnt_o;
	logic [CNT_W-1:0]       dhit_cnt_o;
	logic [CNT_W-1:0]       dmiss_cnt_o;

	logic [31:0] lcg_state = 32'd73;
	logic [31:0] ref_mem [MEM_WORDS];
	int          err_cnt = 0;
	int          cycle_cnt = 0;
	int          tot_ihit = 0;
	int          tot_imiss = 0;
	int          tot_dhit = 0;
	int          tot_dmiss = 0;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	`include "tb_stim_table.svh"

	localparam int TIMEOUT_CYC = 2 * (16 + MEM_WORDS + N_ENTRIES * (MEM_LAT + 8));

	cache_subsys_top dut0 (
		.clk_cpu (clk_cpu), .rst (rst), .run_i (run_i),
		.load_we_i (load_we_i), .load_addr_i (load_addr_i), .load_data_i (load_data_i),
		.req_i (req_i), .we_i (we_i), .addr_i (addr_i),
		.wdata_i (wdata_i), .wstrb_i (wstrb_i),
		.resp_o (resp_o), .rdata_o (rdata_o),
		.ihit_cnt_o (ihit_cnt_o), .imiss_cnt_o (imiss_cnt_o),
		.dhit_cnt_o (dhit_cnt_o), .dmiss_cnt_o (dmiss_cnt_o)
	);

	initial begin
		clk_cpu = 1'b0;
		forever #10 clk_cpu = ~clk_cpu;
	end

	always @(posedge clk_cpu) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == TIMEOUT_CYC) begin
			$display("Run timed out after %0d cycles, no response from the DUT", cycle_cnt);
			$display(">>> FAIL");
			$fatal(1, "simulation stopped by timeout");
		end
	end

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			err_cnt++;
			$display("FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
			$display(">>> FAIL");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	task automatic check_counters();
		check_value("icache hit count", 32'(ihit_cnt_o), 32'(tot_ihit));
		check_value("icache miss count", 32'(imiss_cnt_o), 32'(tot_imiss));
		check_value("dcache hit count", 32'(dhit_cnt_o), 32'(tot_dhit));
		check_value("dcache miss count", 32'(dmiss_cnt_o), 32'(tot_dmiss));
	endtask

	task automatic preload_memory();
		for (int w = 0; w < MEM_WORDS; w++) begin
			ref_mem[w]  = lcg_next();
			load_we_i   = 1'b1;
			load_addr_i = WORD_ADDR_W'(w);
			load_data_i = ref_mem[w];
			@(negedge clk_cpu);
		end
		load_we_i = 1'b0;
	endtask

	// Tag and valid model of both caches; data comes from ref_mem.
	task automatic predict_table();
		bit         ival [16];
		bit         dval [16];
		logic [5:0] itag [16];
		logic [5:0] dtag [16];
		logic [3:0] idx;
		logic [5:0] tag;
		logic [9:0] word;
		for (int k = 0; k < 16; k++) begin
			ival[k] = 1'b0;
			dval[k] = 1'b0;
		end
		for (int i = 0; i < N_ENTRIES; i++) begin
			idx  = stim_tab[i].addr[5:2];
			tag  = stim_tab[i].addr[11:6];
			word = stim_tab[i].addr[11:2];
			stim_tab[i].to_inst = !stim_tab[i].we && (stim_tab[i].addr <= INST_LIMIT);
			if (stim_tab[i].to_inst) begin
				stim_tab[i].hit = ival[idx] && (itag[idx] == tag);
				ival[idx] = 1'b1;
				itag[idx] = tag;
			end else begin
				stim_tab[i].hit = dval[idx] && (dtag[idx] == tag);
				if (!stim_tab[i].we) begin
					dval[idx] = 1'b1; // Refill on read miss only.
					dtag[idx] = tag;
				end else begin
					for (int b = 0; b < 4; b++)
						if (stim_tab[i].strb[b])
							ref_mem[word][8*b +: 8] = stim_tab[i].wdata[8*b +: 8];
				end
			end
			stim_tab[i].rdata = ref_mem[word];
		end
	endtask

	task automatic apply_entry(input int i);
		stim_entry_t e;
		int          lat;
		e       = stim_tab[i];
		req_i   = 1'b1;
		we_i    = e.we;
		addr_i  = e.addr;
		wdata_i = e.wdata;
		wstrb_i = e.strb;
		@(negedge clk_cpu);
		req_i = 1'b0;
		lat   = 1;
		while (!resp_o) begin
			@(negedge clk_cpu);
			lat++;
		end
		if (!e.we)
			check_value($sformatf("entry %0d read data", i), rdata_o, e.rdata);
		if (e.hit && !e.we)
			check_value($sformatf("entry %0d hit latency", i), 32'(lat), 32'd2);
		else
			check_value($sformatf("entry %0d latency at least MEM_LAT+2", i),
				32'(lat >= MEM_LAT + 2), 32'd1);
		if (e.to_inst) begin
			if (e.hit) tot_ihit++;
			else tot_imiss++;
		end else begin
			if (e.hit) tot_dhit++;
			else tot_dmiss++;
		end
		check_counters();
		@(negedge clk_cpu);
	endtask

	// Requests are gated off while run_i is low.
	task automatic idle_while_loading();
		int resp_seen;
		resp_seen = 0;
		run_i     = 1'b0;
		we_i      = 1'b0;
		for (int c = 0; c < 40; c++) begin
			req_i  = (c < 20) && (c % 5 == 0);
			addr_i = (c < 10) ? 32'h0000_0040 : 32'h0000_0800;
			@(negedge clk_cpu);
			if (resp_o)
				resp_seen++;
		end
		req_i = 1'b0;
		check_value("responses while run_i low", 32'(resp_seen), 32'd0);
	endtask

	initial begin
		rst         = 1'b1;
		run_i       = 1'b0;
		load_we_i   = 1'b0;
		load_addr_i = '0;
		load_data_i = '0;
		req_i       = 1'b0;
		we_i        = 1'b0;
		addr_i      = '0;
		wdata_i     = '0;
		wstrb_i     = '0;
		repeat (16) @(negedge clk_cpu);
		rst = 1'b0;
		preload_memory();
		run_i = 1'b1;
		build_table();
		predict_table();
		for (int i = 0; i < N_ENTRIES; i++)
			apply_entry(i);
		idle_while_loading();
		check_counters();
		if (err_cnt == 0) begin
			$display(">>> PASS");
			$finish;
		end else begin
			$display(">>> FAIL");
			$fatal(1, "checks reported mismatches");
		end
	end

endmodule

//--- verilog.f
+incdir+test
hw/cache_cfg_pkg.sv
hw/mem_map_pkg.sv
hw/cpu_port_router.sv
hw/inst_cache.sv
hw/data_cache.sv
hw/main_memory.sv
hw/cache_subsys_top.sv
test/tb_cache_subsys.sv
